/* all.f */
+incdir+src
src/pid_pkg.sv
src/loop_param_if.sv
src/param_regs.sv
src/pid_core.sv
src/output_preproc.sv
src/dac_instr_queue.sv
src/dac_serial.sv
src/pid_top.sv
sim/tb_clk.sv
sim/tb_pid_top.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, then search the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pid_top -f all.f \
	> build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_pid_top > sim.log 2>&1 || { cat sim.log; echo "simulation did not run"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

/* sim/tb_clk.sv */
`timescale 1ns/1ps

module tb_clk (
	output logic clk,
	output logic rst
);
	// 40 ns period, 25 MHz
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);   // held for 5 rising edges
		#2 rst = 1'b0;               // released with the other inputs
	end

endmodule

/* sim/tb_pid_top.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

module tb_pid_top;
	import pid_pkg::*;

	localparam int TIMEOUT_CYCLES = 3500;   // about 40 samples at 80 cycles

	// model copy of one channel's parameters
	typedef struct packed {
		logic [15:0] sp, p, i, d, mn, mx, init;
		logic        lock;
		logic        src;
		logic [9:0]  mlt;
		logic [4:0]  rs;
	} loop_prm_t;

	logic                 clk;
	logic                 rst;
	smp_t                 smp [`PID_N_CH];
	logic [`PID_N_CH-1:0] smp_valid;
	logic                 cfg_we;
	cfg_op_e              cfg_op;
	chan_t                cfg_chan;
	logic [15:0]          cfg_data;
	logic                 dac_nsync;
	logic                 dac_sclk;
	logic                 dac_din;

	loop_prm_t                     shd [`PID_N_CH];        // host side copy
	loop_prm_t                     act [`PID_N_CH];        // committed copy
	logic signed [`PID_W_COMP-1:0] integ [`PID_N_CH];
	logic signed [`PID_W_COMP-1:0] prev_err [`PID_N_CH];
	int                            last_served = 0;

	logic [31:0] rx_frames [$];       // decoded frames in arrival order
	logic [31:0] rx_shift  = '0;
	int          rx_bits   = 0;
	int          errors    = 0;
	int          checks    = 0;
	int          cycles    = 0;
	logic [31:0] lfsr      = 32'h5423;

	tb_clk u_clk (
		.clk (clk),
		.rst (rst)
	);

	pid_top u_dut (
		.clk50     (clk),
		.rst       (rst),
		.smp       (smp),
		.smp_valid (smp_valid),
		.cfg_we    (cfg_we),
		.cfg_op    (cfg_op),
		.cfg_chan  (cfg_chan),
		.cfg_data  (cfg_data),
		.dac_nsync (dac_nsync),
		.dac_sclk  (dac_sclk),
		.dac_din   (dac_din)
	);

	////////////////////////////////////////
	// frame monitor and timeout
	////////////////////////////////////////

	always @(negedge dac_sclk) begin
		if (dac_nsync === 1'b0) begin      // dac samples din on the fall
			rx_shift = {rx_shift[30:0], dac_din};
			rx_bits++;
		end
	end

	// nsync rising closes the frame
	always @(posedge dac_nsync) begin
		if (rx_bits != 0) begin
			checks++;
			assert (rx_bits == `PID_FRAME_BITS) else begin
				errors++;
				$display("ERROR %0t ns: frame ended after %0d bits", $time, rx_bits);
			end
			rx_frames.push_back(rx_shift);
			rx_bits = 0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("%0d checks, %0d errors", checks, errors);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// galois lfsr stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
			r[k] = lfsr[0];
		end
		return r;
	endfunction

	function automatic logic [31:0] rand_signed(input int n);
		logic [31:0] r;
		r = take_bits(n);
		if (r[n-1])
			r = r | (32'hFFFF_FFFF << n);   // sign extend
		return r;
	endfunction

	// prefix, cmd 0011, address, data, feature bits
	function automatic logic [31:0] build_frame(input logic ch, input logic [15:0] w);
		return {4'b0000, 4'b0011, 3'b000, ch, w, 4'b0000};
	endfunction

	// scale, offset and clamp for dac channel d
	function automatic logic [15:0] dac_model(input int d, input logic signed [47:0] r);
		logic signed [47:0] level;
		logic signed [47:0] hi;
		logic signed [47:0] lo;
		logic signed [47:0] base;
		int                 sel;
		sel  = act[d].src;
		hi   = {32'b0, act[d].mx};
		lo   = {32'b0, act[d].mn};
		base = {32'b0, act[d].init};
		if (!act[sel].lock)
			return act[d].init;            // unlocked source parks at init
		level = r * $signed(act[d].mlt);
		level = (level >>> act[d].rs) + base;
		if (level > hi)
			return act[d].mx;
		if (level < lo)
			return act[d].mn;
		return level[15:0];
	endfunction

	task automatic cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic reset_model();
		for (int c = 0; c < `PID_N_CH; c++) begin
			shd[c]      = '0;
			shd[c].mx   = '1;
			shd[c].mlt  = 10'd1;
			integ[c]    = '0;
			prev_err[c] = '0;
		end
		act = shd;
	endtask

	task automatic write_cfg(input cfg_op_e op, input int ch, input logic [15:0] data);
		cfg_we   = 1'b1;
		cfg_op   = op;
		cfg_chan = chan_t'(ch);
		cfg_data = data;
		cycle();
		cfg_we   = 1'b0;
		case (op)
			OP_SETPOINT: shd[ch].sp   = data;
			OP_P:        shd[ch].p    = data;
			OP_I:        shd[ch].i    = data;
			OP_D:        shd[ch].d    = data;
			OP_LOCK:     shd[ch].lock = data[0];
			OP_SRC:      shd[ch].src  = data[0];
			OP_MIN:      shd[ch].mn   = data;
			OP_MAX:      shd[ch].mx   = data;
			OP_INIT:     shd[ch].init = data;
			OP_MLT:      shd[ch].mlt  = data[9:0];
			OP_RS:       shd[ch].rs   = data[4:0];
			OP_CLEAR: begin
				integ[ch]    = '0;
				prev_err[ch] = '0;
			end
			OP_COMMIT:   act = shd;
			default: ;
		endcase
	endtask

	task automatic setup_pid(input int c, input logic [15:0] sp, p, i, d, input logic lock);
		write_cfg(OP_SETPOINT, c, sp);
		write_cfg(OP_P, c, p);
		write_cfg(OP_I, c, i);
		write_cfg(OP_D, c, d);
		write_cfg(OP_LOCK, c, {15'b0, lock});
	endtask

	task automatic setup_out(input int c, input logic [15:0] init, mn, mx, mlt, rs);
		write_cfg(OP_INIT, c, init);
		write_cfg(OP_MIN, c, mn);
		write_cfg(OP_MAX, c, mx);
		write_cfg(OP_MLT, c, mlt);
		write_cfg(OP_RS, c, rs);
	endtask

	// one sample per masked input and a compare of the frames that follow
	task automatic run_step(input logic [1:0] mask, input smp_t s0, input smp_t s1);
		smp_t                          s [`PID_N_CH];
		logic signed [`PID_W_COMP-1:0] res [`PID_N_CH];
		logic signed [`PID_W_COMP-1:0] err;
		logic [31:0]                   exp_q [$];
		int                            src;
		int                            ch;
		int                            first;
		s[0] = s0;
		s[1] = s1;
		for (int c = 0; c < `PID_N_CH; c++) begin
			res[c] = '0;
			if (!mask[c])
				continue;
			err = $signed(act[c].sp) - s[c];
			if (act[c].lock) begin
				integ[c]    = integ[c] + err;      // i term sees the new sum
				res[c]      = $signed(act[c].p) * err + $signed(act[c].i) * integ[c]
				            + $signed(act[c].d) * (err - prev_err[c]);
				prev_err[c] = err;
			end else begin
				integ[c]    = '0;
				prev_err[c] = '0;
			end
		end
		first = last_served;                     // round robin from last served
		for (int k = 0; k < `PID_N_CH; k++) begin
			ch  = (first + k) % `PID_N_CH;
			src = act[ch].src;
			if (mask[src]) begin
				exp_q.push_back(build_frame(ch[0], dac_model(ch, res[src])));
				last_served = ch;
			end
		end
		rx_frames.delete();
		smp[0]    = s0;
		smp[1]    = s1;
		smp_valid = mask;
		cycle();
		smp_valid = '0;
		while (rx_frames.size() < exp_q.size())
			cycle();
		repeat (6) cycle();                      // past gap and done where a further frame would begin
		checks++;
		assert (rx_frames.size() == exp_q.size() && rx_bits == 0) else begin
			errors++;
			$display("ERROR %0t ns: %0d frames seen, %0d expected, %0d bits of a further frame",
				$time, rx_frames.size(), exp_q.size(), rx_bits);
		end
		for (int k = 0; k < exp_q.size() && k < rx_frames.size(); k++) begin
			checks++;
			assert (rx_frames[k] == exp_q[k]) else begin
				errors++;
				$display("ERROR %0t ns: frame %0d is %h, expected %h (chan %0d, word %h)",
					$time, k, rx_frames[k], exp_q[k], exp_q[k][20], exp_q[k][19:4]);
			end
		end
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		cfg_we    = 1'b0;
		cfg_op    = OP_SETPOINT;
		cfg_chan  = '0;
		cfg_data  = '0;
		smp_valid = '0;
		smp[0]    = '0;
		smp[1]    = '0;
		reset_model();
		wait (rst === 1'b0);
		cycle();

		// 1. idle after reset
		checks++;
		assert (dac_nsync === 1'b1 && dac_sclk === 1'b0 && dac_din === 1'b0) else begin
			errors++;
			$display("ERROR %0t ns: serial port not idle after reset", $time);
		end
		repeat (40) cycle();
		checks++;
		assert (rx_frames.size() == 0 && rx_bits == 0) else begin
			errors++;
			$display("ERROR %0t ns: frame activity without samples", $time);
		end

		// 2. frames carry init while unlocked
		for (int c = 0; c < `PID_N_CH; c++) begin
			write_cfg(OP_SRC, c, 16'(c));          // each dac follows its own input
			setup_pid(c, 16'(take_bits(16)), 16'(take_bits(8)), 0, 0, 1'b0);
			setup_out(c, 16'(take_bits(16)), 16'h0000, 16'hFFFF, 1, 0);
		end
		write_cfg(OP_COMMIT, 0, 0);
		run_step(2'b11, smp_t'(rand_signed(18)), smp_t'(rand_signed(18)));
		run_step(2'b11, smp_t'(rand_signed(18)), smp_t'(rand_signed(18)));

		// 3. p gain only and shadow writes held until commit
		for (int c = 0; c < `PID_N_CH; c++) begin
			setup_pid(c, 16'(rand_signed(12)), 16'(take_bits(8)), 0, 0, 1'b1);
			setup_out(c, 16'h8000, 16'h0400, 16'hF000, 3, 12);
		end
		run_step(2'b11, smp_t'(rand_signed(18)), smp_t'(rand_signed(18)));   // still old set
		write_cfg(OP_COMMIT, 0, 0);
		run_step(2'b11, smp_t'(rand_signed(18)), smp_t'(rand_signed(18)));
		run_step(2'b11, smp_t'(rand_signed(18)), smp_t'(rand_signed(18)));
		write_cfg(OP_P, 0, 16'd0);                  // no commit follows
		run_step(2'b11, smp_t'(rand_signed(18)), smp_t'(rand_signed(18)));

		// 4. i and d gains followed by a clear
		for (int c = 0; c < `PID_N_CH; c++) begin
			setup_pid(c, 16'(rand_signed(10)), 16'(take_bits(8)), 16'(take_bits(4)) + 16'd1,
				16'(take_bits(6)), 1'b1);
			setup_out(c, 16'h8000, 16'h0000, 16'hFFFF, 3, 6);
			write_cfg(OP_CLEAR, c, 0);
		end
		write_cfg(OP_COMMIT, 0, 0);
		for (int n = 0; n < 3; n++)
			run_step(2'b11, smp_t'(rand_signed(10)), smp_t'(rand_signed(10)));
		write_cfg(OP_CLEAR, 0, 0);
		write_cfg(OP_CLEAR, 1, 0);
		run_step(2'b11, smp_t'(rand_signed(10)), smp_t'(rand_signed(10)));
		run_step(2'b11, smp_t'(rand_signed(10)), smp_t'(rand_signed(10)));

		// 5. clamp at both ends
		for (int c = 0; c < `PID_N_CH; c++) begin
			setup_pid(c, 16'd0, 16'd200, 16'd0, 16'd0, 1'b1);
			setup_out(c, 16'h8000, 16'h1000, 16'hE000, 1, 0);
		end
		write_cfg(OP_COMMIT, 0, 0);
		run_step(2'b11, smp_t'(100000), smp_t'(-100000));
		run_step(2'b11, smp_t'(-100000), smp_t'(100000));

		// 6. crossed sources and round robin order
		write_cfg(OP_SRC, 0, 16'd1);
		write_cfg(OP_SRC, 1, 16'd0);
		setup_out(0, 16'h4000, 16'h0000, 16'hFFFF, 16'd5, 8);
		setup_out(1, 16'hC000, 16'h0000, 16'hFFFF, 16'h03FD, 8);   // multiplier -3
		for (int c = 0; c < `PID_N_CH; c++)
			setup_pid(c, 16'(rand_signed(12)), 16'(take_bits(8)), 16'd0, 16'd0, 1'b1);
		write_cfg(OP_COMMIT, 0, 0);
		run_step(2'b11, smp_t'(rand_signed(12)), smp_t'(rand_signed(12)));
		run_step(2'b10, smp_t'(rand_signed(12)), smp_t'(rand_signed(12)));   // dac 0 only
		run_step(2'b11, smp_t'(rand_signed(12)), smp_t'(rand_signed(12)));

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* src/dac_instr_queue.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

module dac_instr_queue (
	input  logic                  clk,
	input  logic                  rst,
	input  pid_pkg::dac_word_t    words [`PID_N_CH],
	input  logic [`PID_N_CH-1:0]  words_valid,
	input  logic                  done,        // serial writer finished
	output logic                  start,
	output pid_pkg::dac_word_t    start_word,
	output pid_pkg::chan_t        start_chan
);
	import pid_pkg::*;

	logic [`PID_N_CH-1:0] pending;
	dac_word_t            held [`PID_N_CH];   // latest word per channel
	chan_t                last;               // last channel served
	chan_t                sel;
	logic                 found;
	logic                 busy;               // start seen, waiting on done
	int                   idx;

	// round robin search starting at the last served channel
	always_comb begin
		sel   = last;
		found = 1'b0;
		for (int k = 0; k < `PID_N_CH; k++) begin
			idx = (int'(last) + k) % `PID_N_CH;
			if (!found && pending[idx]) begin
				sel   = chan_t'(idx);
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			busy    <= 1'b0;
			start   <= 1'b0;
			last    <= '0;
		end else begin
			start <= 1'b0;
			if (done)
				busy <= 1'b0;
			if (!busy && found) begin
				start        <= 1'b1;
				busy         <= 1'b1;
				last         <= sel;
				pending[sel] <= 1'b0;
			end
			// a fresh word re-arms even the channel being issued
			for (int c = 0; c < `PID_N_CH; c++)
				if (words_valid[c])
					pending[c] <= 1'b1;
		end
	end

	// word storage, newest value overwrites
	always_ff @(posedge clk) begin
		for (int c = 0; c < `PID_N_CH; c++)
			if (words_valid[c])
				held[c] <= words[c];
		if (!busy && found) begin
			start_word <= held[sel];
			start_chan <= sel;
		end
	end

endmodule

/* src/dac_serial.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

module dac_serial (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  pid_pkg::dac_word_t  word,
	input  pid_pkg::chan_t      chan,
	output logic                nsync,
	output logic                sclk,
	output logic                din,
	output logic                done
);
	import pid_pkg::*;

	dac_state_e                               state;
	logic [`PID_FRAME_BITS-1:0]               frame;
	logic [`PID_FRAME_BITS-1:0]               shreg;   // next bits at the top
	logic [$clog2(2*`PID_FRAME_BITS)-1:0]     cnt;     // two clk per bit

	////////////////////////////////////////
	// dac8568 write frame
	////////////////////////////////////////

	// prefix, write and update command, address, data, feature bits
	assign frame = {4'b0000, 4'b0011, {(4-`PID_W_CHS){1'b0}}, chan, word, 4'b0000};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
			nsync <= 1'b1;
			sclk  <= 1'b0;
			din   <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: if (start) begin
					state <= SHIFT;
					cnt   <= '0;
					nsync <= 1'b0;
					sclk  <= 1'b1;               // first high phase
					din   <= frame[`PID_FRAME_BITS-1];
				end
				SHIFT: begin
					cnt <= cnt + 1'b1;
					if (!cnt[0]) begin
						sclk <= 1'b0;            // falling edge, dac samples here
					end else if (&cnt) begin     // last low phase done
						state <= GAP;
						cnt   <= '0;
						nsync <= 1'b1;
						sclk  <= 1'b0;
						din   <= 1'b0;
					end else begin
						sclk <= 1'b1;
						din  <= shreg[`PID_FRAME_BITS-1];   // new bit on the rise
					end
				end
				GAP: begin
					cnt <= cnt + 1'b1;
					if (cnt[0])
						state <= IDLE;
					else
						done <= 1'b1;            // high in the last gap cycle
				end
				default: state <= IDLE;
			endcase
		end
	end

	// shift register, msb first
	always_ff @(posedge clk) begin
		if (state == IDLE && start)
			shreg <= frame << 1;
		else if (state == SHIFT && cnt[0])
			shreg <= shreg << 1;
	end

endmodule

/* src/loop_param_if.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

interface loop_param_if;
	import pid_pkg::*;

	// pid side, indexed by input channel
	coef_t                 setpoint [`PID_N_CH];
	coef_t                 p_coef   [`PID_N_CH];
	coef_t                 i_coef   [`PID_N_CH];
	coef_t                 d_coef   [`PID_N_CH];
	logic [`PID_N_CH-1:0]  lock_en;
	logic [`PID_N_CH-1:0]  clear;   // single cycle

	// output side, indexed by dac channel
	chan_t                 src_sel     [`PID_N_CH];
	dac_word_t             out_min     [`PID_N_CH];
	dac_word_t             out_max     [`PID_N_CH];
	dac_word_t             out_init    [`PID_N_CH];
	mlt_t                  multiplier  [`PID_N_CH];
	logic [`PID_W_RS-1:0]  right_shift [`PID_N_CH];

	modport regs (output setpoint, p_coef, i_coef, d_coef, lock_en, clear,
		src_sel, out_min, out_max, out_init, multiplier, right_shift);

	modport pid (input setpoint, p_coef, i_coef, d_coef, lock_en, clear);

	// lock_en here so the opp can follow the lock state of its source
	modport opp (input src_sel, out_min, out_max, out_init, multiplier, right_shift,
		lock_en);

endinterface

/* src/output_preproc.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

module output_preproc (
	input  logic                  clk,
	input  logic                  rst,
	input  pid_pkg::chan_t        chan,      // dac channel of this instance
	input  pid_pkg::comp_t        results [`PID_N_CH],
	input  logic [`PID_N_CH-1:0]  results_valid,
	loop_param_if.opp             prm,
	output pid_pkg::dac_word_t    word,
	output logic                  word_valid
);
	import pid_pkg::*;

	chan_t     sel;        // pid channel feeding us
	comp_t     src;
	logic      src_valid;
	logic      src_lock;   // lock state of the selected pid
	comp_t     prod;
	comp_t     shifted;
	comp_t     level;      // init + scaled result, before clamp
	dac_word_t clamped;

	////////////////////////////////////////
	// source select and scaling
	////////////////////////////////////////

	always_comb begin
		sel       = prm.src_sel[chan];
		src       = results[sel];
		src_valid = results_valid[sel];
		src_lock  = prm.lock_en[sel];

		prod    = src * comp_t'(prm.multiplier[chan]);
		shifted = prod >>> prm.right_shift[chan];        // arithmetic, keeps sign
		level   = comp_t'(prm.out_init[chan]) + shifted; // init is unsigned, zero extends

		// clamp in the signed domain, min and max are unsigned codes
		if (level > comp_t'(prm.out_max[chan]))
			clamped = prm.out_max[chan];
		else if (level < comp_t'(prm.out_min[chan]))
			clamped = prm.out_min[chan];
		else
			clamped = dac_word_t'(level);
	end

	always_ff @(posedge clk) begin
		if (rst)
			word_valid <= 1'b0;
		else
			word_valid <= src_valid;
	end

	// unlocked output parks at init
	always_ff @(posedge clk) begin
		if (src_valid)
			word <= src_lock ? clamped : prm.out_init[chan];
	end

endmodule

/* src/param_regs.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

module param_regs (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cfg_we,
	input  pid_pkg::cfg_op_e       cfg_op,
	input  pid_pkg::chan_t         cfg_chan,
	input  logic [`PID_W_COEF-1:0] cfg_data,
	loop_param_if.regs             prm
);
	import pid_pkg::*;

	// shadow copies, written by the host
	coef_t                 sh_setpoint [`PID_N_CH];
	coef_t                 sh_p        [`PID_N_CH];
	coef_t                 sh_i        [`PID_N_CH];
	coef_t                 sh_d        [`PID_N_CH];
	logic [`PID_N_CH-1:0]  sh_lock;
	chan_t                 sh_src      [`PID_N_CH];
	dac_word_t             sh_min      [`PID_N_CH];
	dac_word_t             sh_max      [`PID_N_CH];
	dac_word_t             sh_init     [`PID_N_CH];
	mlt_t                  sh_mlt      [`PID_N_CH];
	logic [`PID_W_RS-1:0]  sh_rs       [`PID_N_CH];

	logic commit;

	assign commit = cfg_we && (cfg_op == OP_COMMIT);

	// integrator clear goes straight through, no commit needed
	always_comb begin
		for (int c = 0; c < `PID_N_CH; c++)
			prm.clear[c] = cfg_we && (cfg_op == OP_CLEAR) && (cfg_chan == chan_t'(c));
	end

	////////////////////////////////////////
	// shadow bank
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < `PID_N_CH; c++) begin
				sh_setpoint[c] <= '0;
				sh_p[c]        <= '0;
				sh_i[c]        <= '0;
				sh_d[c]        <= '0;
				sh_lock[c]     <= 1'b0;
				sh_src[c]      <= '0;
				sh_min[c]      <= '0;
				sh_max[c]      <= '1;          // full scale
				sh_init[c]     <= '0;
				sh_mlt[c]      <= mlt_t'(1);   // unity gain
				sh_rs[c]       <= '0;
			end
		end else if (cfg_we) begin
			case (cfg_op)
				OP_SETPOINT: sh_setpoint[cfg_chan] <= coef_t'(cfg_data);
				OP_P:        sh_p[cfg_chan]        <= coef_t'(cfg_data);
				OP_I:        sh_i[cfg_chan]        <= coef_t'(cfg_data);
				OP_D:        sh_d[cfg_chan]        <= coef_t'(cfg_data);
				OP_LOCK:     sh_lock[cfg_chan]     <= cfg_data[0];
				OP_SRC:      sh_src[cfg_chan]      <= cfg_data[`PID_W_CHS-1:0];
				OP_MIN:      sh_min[cfg_chan]      <= dac_word_t'(cfg_data);
				OP_MAX:      sh_max[cfg_chan]      <= dac_word_t'(cfg_data);
				OP_INIT:     sh_init[cfg_chan]     <= dac_word_t'(cfg_data);
				OP_MLT:      sh_mlt[cfg_chan]      <= cfg_data[`PID_W_MLT-1:0];
				OP_RS:       sh_rs[cfg_chan]       <= cfg_data[`PID_W_RS-1:0];
				default: ;  // clear and commit hold no shadow
			endcase
		end
	end

	////////////////////////////////////////
	// active bank
	////////////////////////////////////////

	// same reset values as the shadows
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < `PID_N_CH; c++) begin
				prm.setpoint[c]    <= '0;
				prm.p_coef[c]      <= '0;
				prm.i_coef[c]      <= '0;
				prm.d_coef[c]      <= '0;
				prm.lock_en[c]     <= 1'b0;
				prm.src_sel[c]     <= '0;
				prm.out_min[c]     <= '0;
				prm.out_max[c]     <= '1;
				prm.out_init[c]    <= '0;
				prm.multiplier[c]  <= mlt_t'(1);
				prm.right_shift[c] <= '0;
			end
		end else if (commit) begin
			for (int c = 0; c < `PID_N_CH; c++) begin
				prm.setpoint[c]    <= sh_setpoint[c];
				prm.p_coef[c]      <= sh_p[c];
				prm.i_coef[c]      <= sh_i[c];
				prm.d_coef[c]      <= sh_d[c];
				prm.lock_en[c]     <= sh_lock[c];
				prm.src_sel[c]     <= sh_src[c];
				prm.out_min[c]     <= sh_min[c];
				prm.out_max[c]     <= sh_max[c];
				prm.out_init[c]    <= sh_init[c];
				prm.multiplier[c]  <= sh_mlt[c];
				prm.right_shift[c] <= sh_rs[c];
			end
		end
	end

endmodule

/* src/pid_cfg.svh */
`ifndef PID_CFG_SVH
`define PID_CFG_SVH

////////////////////////////////////////
// channel counts
////////////////////////////////////////

`define PID_N_CH        2   // input channels and dac channels
`define PID_W_CHS       1   // channel index width

////////////////////////////////////////
// data path widths
////////////////////////////////////////

`define PID_W_SMP       18  // adc sample
`define PID_W_COMP      48  // pid computation
`define PID_W_COEF      16  // setpoint and gains, also host data word
`define PID_W_DAC       16  // dac code
`define PID_W_MLT       10  // output multiplier
`define PID_W_RS        5   // right shift amount

// dac8568 write frame length
`define PID_FRAME_BITS  32

`endif

/* src/pid_core.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

module pid_core (
	input  logic            clk,
	input  logic            rst,
	input  pid_pkg::chan_t  chan,        // which slice of prm belongs to us
	input  pid_pkg::smp_t   smp,
	input  logic            smp_valid,
	loop_param_if.pid       prm,
	output pid_pkg::comp_t  result,
	output logic            result_valid
);
	import pid_pkg::*;

	comp_t err;        // setpoint - sample
	comp_t integ;      // running sum of errors
	comp_t integ_nx;
	comp_t prev_err;
	comp_t sum;

	////////////////////////////////////////
	// pid sum
	////////////////////////////////////////

	always_comb begin
		// everything sign extended to the computation width first
		err      = comp_t'(prm.setpoint[chan]) - comp_t'(smp);
		integ_nx = integ + err;   // i term uses the updated integrator
		sum      = comp_t'(prm.p_coef[chan]) * err
		         + comp_t'(prm.i_coef[chan]) * integ_nx
		         + comp_t'(prm.d_coef[chan]) * (err - prev_err);
	end

	// loop state
	always_ff @(posedge clk) begin
		if (rst) begin
			integ        <= '0;
			prev_err     <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= smp_valid;    // one cycle latency
			if (smp_valid) begin
				if (prm.lock_en[chan]) begin
					integ    <= integ_nx;
					prev_err <= err;
				end else begin
					integ    <= '0;       // unlocked loop holds no history
					prev_err <= '0;
				end
			end
			if (prm.clear[chan]) begin     // clear beats a sample in the same cycle
				integ    <= '0;
				prev_err <= '0;
			end
		end
	end

	// result register
	always_ff @(posedge clk) begin
		if (smp_valid)
			result <= prm.lock_en[chan] ? sum : '0;
	end

endmodule

/* src/pid_pkg.sv */
`include "pid_cfg.svh"

package pid_pkg;

	////////////////////////////////////////
	// data types
	////////////////////////////////////////

	typedef logic signed [`PID_W_SMP-1:0]  smp_t;       // raw input sample
	typedef logic signed [`PID_W_COMP-1:0] comp_t;      // pid sum
	typedef logic signed [`PID_W_COEF-1:0] coef_t;      // setpoint or gain
	typedef logic        [`PID_W_DAC-1:0]  dac_word_t;  // straight binary dac code
	typedef logic signed [`PID_W_MLT-1:0]  mlt_t;       // opp scale factor
	typedef logic        [`PID_W_CHS-1:0]  chan_t;

	// host opcodes, one per shadow register plus clear and commit
	typedef enum logic [3:0] {
		OP_SETPOINT = 4'd0,
		OP_P        = 4'd1,
		OP_I        = 4'd2,
		OP_D        = 4'd3,
		OP_LOCK     = 4'd4,   // data bit 0
		OP_CLEAR    = 4'd5,   // immediate, no shadow
		OP_SRC      = 4'd6,   // pid source for this dac channel
		OP_MIN      = 4'd7,
		OP_MAX      = 4'd8,
		OP_INIT     = 4'd9,
		OP_MLT      = 4'd10,
		OP_RS       = 4'd11,
		OP_COMMIT   = 4'd12   // shadow -> active, all channels
	} cfg_op_e;

	// serial writer states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		SHIFT = 2'd1,
		GAP   = 2'd2
	} dac_state_e;

endpackage

/* src/pid_top.sv */
`timescale 1ns/1ps

`include "pid_cfg.svh"

module pid_top (
	input  logic                   clk50,
	input  logic                   rst,

	// parallel samples
	input  pid_pkg::smp_t          smp [`PID_N_CH],
	input  logic [`PID_N_CH-1:0]   smp_valid,

	// host parameter writes
	input  logic                   cfg_we,
	input  pid_pkg::cfg_op_e       cfg_op,
	input  pid_pkg::chan_t         cfg_chan,
	input  logic [`PID_W_COEF-1:0] cfg_data,

	// dac8568 serial port
	output logic                   dac_nsync,
	output logic                   dac_sclk,
	output logic                   dac_din
);
	import pid_pkg::*;

	comp_t                pid_result [`PID_N_CH];
	logic [`PID_N_CH-1:0] pid_valid;
	dac_word_t            opp_word   [`PID_N_CH];
	logic [`PID_N_CH-1:0] opp_valid;
	logic                 diq_start;
	dac_word_t            diq_word;
	chan_t                diq_chan;
	logic                 dac_done;

	loop_param_if prm ();

	param_regs u_regs (
		.clk      (clk50),
		.rst      (rst),
		.cfg_we   (cfg_we),
		.cfg_op   (cfg_op),
		.cfg_chan (cfg_chan),
		.cfg_data (cfg_data),
		.prm      (prm)
	);

	////////////////////////////////////////
	// per channel loop
	////////////////////////////////////////

	for (genvar g = 0; g < `PID_N_CH; g++) begin : g_ch
		pid_core u_pid (
			.clk          (clk50),
			.rst          (rst),
			.chan         (chan_t'(g)),
			.smp          (smp[g]),
			.smp_valid    (smp_valid[g]),
			.prm          (prm),
			.result       (pid_result[g]),
			.result_valid (pid_valid[g])
		);

		// dac channel g, source picked by its src_sel
		output_preproc u_opp (
			.clk           (clk50),
			.rst           (rst),
			.chan          (chan_t'(g)),
			.results       (pid_result),
			.results_valid (pid_valid),
			.prm           (prm),
			.word          (opp_word[g]),
			.word_valid    (opp_valid[g])
		);
	end

	dac_instr_queue u_diq (
		.clk         (clk50),
		.rst         (rst),
		.words       (opp_word),
		.words_valid (opp_valid),
		.done        (dac_done),
		.start       (diq_start),
		.start_word  (diq_word),
		.start_chan  (diq_chan)
	);

	dac_serial u_dac (
		.clk   (clk50),
		.rst   (rst),
		.start (diq_start),
		.word  (diq_word),
		.chan  (diq_chan),
		.nsync (dac_nsync),
		.sclk  (dac_sclk),
		.din   (dac_din),
		.done  (dac_done)
	);

endmodule
